// File: rtl/mem_req_if.sv
// valid/ready request channel with source, sink and monitor modports
`timescale 1ns/100ps
`default_nettype none

interface mem_req_if;

    logic                  valid;
    logic                  ready;
    mem_req_pkg::mem_req_t req; // stable while valid && !ready

    modport source (
        output valid,
        output req,
        input  ready
    );

    modport sink (
        input  valid,
        input  req,
        output ready
    );

    modport monitor (
        input valid,
        input ready,
        input req
    );

endinterface

`default_nettype wire

// File: rtl/mem_req_pkg.sv
// address, data and mask types plus the request record and queue depth
`default_nettype none

package mem_req_pkg;

    localparam int ADDR_W = 22;
    localparam int ROW_W  = 13;
    localparam int COL_W  = 9;
    localparam int BANK_W = 2;

    localparam int QUEUE_DEPTH = 4;

    typedef logic [ADDR_W-1:0] addr_t; // row on top, column below
    typedef logic [BANK_W-1:0] bank_t;
    typedef logic [15:0]       word_t;
    typedef logic [31:0]       dword_t;
    typedef logic [1:0]        mask_t; // set bit blocks that byte

    typedef struct packed {
        addr_t addr;
        bank_t bank;
        logic  wr;   // 1 for write
        word_t data;
        mask_t mask;
    } mem_req_t;

endpackage

`default_nettype wire

// File: rtl/req_merge.sv
// request merger combining game and rom-download requests into one request stream
`timescale 1ns/100ps
`default_nettype none

module req_merge (
    input  logic               clk,
    input  logic               rst,
    input  logic               downloading,
    input  logic               prog_we,
    input  mem_req_pkg::addr_t prog_addr,
    input  mem_req_pkg::bank_t prog_bank,
    input  byte                prog_data,
    input  mem_req_pkg::mask_t prog_mask,
    input  logic               read_req,
    input  logic               rnw,
    input  mem_req_pkg::addr_t game_addr,
    input  mem_req_pkg::bank_t game_bank,
    input  mem_req_pkg::word_t data_write,
    input  mem_req_pkg::mask_t wr_mask,
    output logic               sdram_ack,
    mem_req_if.source          req_out
);

    mem_req_pkg::mem_req_t pend; // the one pending request
    logic out_valid;
    logic src_game;  // pending entry came from the game
    logic game_busy; // game request taken, wait for read_req low
    logic can_load;
    logic dl_take;
    logic game_take;

    assign req_out.valid = out_valid;
    assign req_out.req   = pend;

    // slot free now or emptied this cycle
    assign can_load  = !out_valid || req_out.ready;
    assign dl_take   = downloading && prog_we && can_load; // dropped if no room
    assign game_take = !downloading && read_req && !game_busy && can_load;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid <= 1'b0;
            src_game  <= 1'b0;
            game_busy <= 1'b0;
            sdram_ack <= 1'b0;
        end else begin
            sdram_ack <= out_valid && req_out.ready && src_game; // one cycle
            if (dl_take || game_take) begin
                out_valid <= 1'b1;
                src_game  <= game_take;
            end else if (req_out.ready) begin
                out_valid <= 1'b0;
            end
            if (game_take)
                game_busy <= 1'b1;
            else if (!read_req)
                game_busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (dl_take) begin
            // download byte goes to both halves, mask picks the lane
            pend <= '{addr: prog_addr, bank: prog_bank, wr: 1'b1,
                      data: {prog_data, prog_data}, mask: prog_mask};
        end else if (game_take) begin
            pend <= '{addr: game_addr, bank: game_bank, wr: !rnw,
                      data: data_write, mask: wr_mask};
        end
    end

endmodule

`default_nettype wire

// File: rtl/req_queue.sv
// request fifo with read/write pointers and occupancy count
`timescale 1ns/100ps
`default_nettype none

module req_queue #(
    parameter int DEPTH = mem_req_pkg::QUEUE_DEPTH // power of two
) (
    input  logic       clk,
    input  logic       rst,
    mem_req_if.sink    push_side,
    mem_req_if.source  pop_side
);

    localparam int PTR_W = $clog2(DEPTH);

    mem_req_pkg::mem_req_t store [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;  // 0 .. DEPTH
    logic full;
    logic empty;
    logic push;
    logic pop;

    assign full  = count == (PTR_W+1)'(DEPTH);
    assign empty = count == '0;

    assign push_side.ready = !full;
    assign pop_side.valid  = !empty;
    assign pop_side.req    = store[rd_ptr]; // head of queue

    assign push = push_side.valid && !full;
    assign pop  = pop_side.ready && !empty;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1; // wraps, depth is 2^n
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // none or both
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push)
            store[wr_ptr] <= push_side.req;
    end

endmodule

`default_nettype wire

// File: rtl/sdram_cmd_pkg.sv
// sdram command encodings, mode register word, init and refresh timing constants
`default_nettype none

package sdram_cmd_pkg;

    // {n_cs, n_ras, n_cas, n_we}
    typedef enum logic [3:0] {
        load_mode    = 4'b0000,
        auto_refresh = 4'b0001,
        precharge    = 4'b0010,
        activate     = 4'b0011,
        write        = 4'b0100,
        read         = 4'b0101,
        burst_stop   = 4'b0110,
        nop          = 4'b0111,
        inhibit      = 4'b1000
    } cmd_t;

    // single write, cas 2, sequential, burst of 2
    localparam logic [12:0] MODE_WORD = 13'b00_1_00_010_0_001;

    localparam int CAS_LAT = 2;

    // power-up idle, much shorter than real parts need
    localparam logic [13:0] INIT_WAIT = 14'd200;

    // nop cycles after each init command
    localparam logic [13:0] INIT_PRE_WAIT = 14'd2;
    localparam logic [13:0] INIT_REF_WAIT = 14'd11;
    localparam logic [13:0] INIT_MRS_WAIT = 14'd3;
    localparam logic [13:0] INIT_END_WAIT = 14'd4;

    localparam int REFRESH_GAP = 2; // idle cycles before refresh is due

endpackage

`default_nettype wire

// File: rtl/sdram_ctrl.sv
// sdram controller, power-up sequence, access steps, refresh timer, read capture
`timescale 1ns/100ps
`default_nettype none

module sdram_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          refresh_en,
    mem_req_if.sink                       req_in,
    output logic                          init_busy,
    output logic                          data_rdy,
    output mem_req_pkg::dword_t           data_read,
    inout  wire mem_req_pkg::word_t       sdram_dq,
    output logic [mem_req_pkg::ROW_W-1:0] sdram_a,
    output mem_req_pkg::bank_t            sdram_ba,
    output logic                          sdram_dqml,
    output logic                          sdram_dqmh,
    output logic                          sdram_n_cs,
    output logic                          sdram_n_ras,
    output logic                          sdram_n_cas,
    output logic                          sdram_n_we,
    output logic                          sdram_cke
);

    sdram_cmd_pkg::cmd_t cmd;

    logic [13:0] wait_cnt;   // init nop counter
    logic [2:0]  init_step;
    logic [2:0]  acc_step;   // 0 idle, 1..6 access or refresh

    logic [mem_req_pkg::COL_W-1:0] col_addr;
    mem_req_pkg::word_t dq_out;
    mem_req_pkg::mask_t wr_mask;

    logic write_cycle;
    logic read_cycle;
    logic refresh_cycle;
    logic hold_bus;

    logic [sdram_cmd_pkg::REFRESH_GAP-1:0] refresh_sr;
    logic refresh_ok; // refresh due, goes ahead of next request
    logic start;

    assign {sdram_n_cs, sdram_n_ras, sdram_n_cas, sdram_n_we} = cmd;
    assign sdram_cke = 1'b1;

    // drive on writes, park at zero when idle, float for read data
    assign sdram_dq = write_cycle ? dq_out : (hold_bus ? '0 : 'z);

    assign req_in.ready = !init_busy && (acc_step == 3'd0) && !refresh_ok;
    assign start        = req_in.valid && req_in.ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cmd           <= sdram_cmd_pkg::nop;
            sdram_a       <= '0;
            sdram_ba      <= '0;
            {sdram_dqmh, sdram_dqml} <= 2'b00;
            wait_cnt      <= sdram_cmd_pkg::INIT_WAIT;
            init_step     <= '0;
            init_busy     <= 1'b1;
            acc_step      <= '0;
            write_cycle   <= 1'b0;
            read_cycle    <= 1'b0;
            refresh_cycle <= 1'b0;
            hold_bus      <= 1'b1;
            refresh_sr    <= '0;
            refresh_ok    <= 1'b0;
            data_rdy      <= 1'b0;
        end else if (init_busy) begin
            if (wait_cnt != '0) begin
                wait_cnt <= wait_cnt - 1'b1;
                cmd      <= sdram_cmd_pkg::nop;
            end else begin
                init_step <= init_step + 1'b1;
                case (init_step)
                    3'd0: begin
                        cmd         <= sdram_cmd_pkg::precharge;
                        sdram_a[10] <= 1'b1; // all banks
                        wait_cnt    <= sdram_cmd_pkg::INIT_PRE_WAIT;
                    end
                    3'd1: begin
                        cmd      <= sdram_cmd_pkg::auto_refresh;
                        wait_cnt <= sdram_cmd_pkg::INIT_REF_WAIT;
                    end
                    3'd2: begin
                        cmd      <= sdram_cmd_pkg::load_mode;
                        sdram_a  <= sdram_cmd_pkg::MODE_WORD;
                        wait_cnt <= sdram_cmd_pkg::INIT_MRS_WAIT;
                    end
                    3'd3: begin
                        cmd         <= sdram_cmd_pkg::precharge;
                        sdram_a[10] <= 1'b1;
                        wait_cnt    <= sdram_cmd_pkg::INIT_END_WAIT;
                    end
                    default: begin
                        cmd       <= sdram_cmd_pkg::nop;
                        init_busy <= 1'b0; // hand off to access steps
                    end
                endcase
            end
        end else begin
            cmd      <= sdram_cmd_pkg::nop; // default between commands
            data_rdy <= 1'b0;
            if (acc_step != 3'd0 || start || refresh_ok)
                acc_step <= acc_step + 1'b1;
            case (acc_step)
                3'd0: begin
                    hold_bus <= 1'b1;
                    {sdram_dqmh, sdram_dqml} <= 2'b00;
                    if (refresh_ok) begin
                        cmd           <= sdram_cmd_pkg::auto_refresh;
                        refresh_cycle <= 1'b1;
                        refresh_ok    <= 1'b0;
                        refresh_sr    <= '0;
                    end else if (start) begin
                        cmd         <= sdram_cmd_pkg::activate;
                        sdram_a     <= req_in.req.addr[mem_req_pkg::ADDR_W-1 -: mem_req_pkg::ROW_W];
                        sdram_ba    <= req_in.req.bank;
                        write_cycle <= req_in.req.wr;
                        read_cycle  <= !req_in.req.wr;
                        refresh_sr  <= '0; // an access restarts the idle count
                    end else if (refresh_en) begin
                        {refresh_ok, refresh_sr} <= {refresh_sr, 1'b1};
                    end else begin
                        refresh_sr <= '0;
                    end
                end
                3'd2: begin
                    if (!refresh_cycle) begin
                        cmd     <= write_cycle ? sdram_cmd_pkg::write : sdram_cmd_pkg::read;
                        sdram_a <= {2'b00, 1'b1, 1'b0, col_addr}; // a10 auto precharge
                        // reads take both bytes
                        {sdram_dqmh, sdram_dqml} <= write_cycle ? wr_mask : 2'b00;
                    end
                end
                3'd3: begin
                    if (read_cycle)
                        hold_bus <= 1'b0; // release bus for the burst
                end
                3'd4: begin
                    write_cycle <= 1'b0; // write data already taken
                end
                3'd5: begin
                    if (!refresh_cycle) begin
                        data_rdy   <= 1'b1;
                        read_cycle <= 1'b0;
                        hold_bus   <= 1'b1;
                        acc_step   <= '0;
                    end
                end
                3'd6: begin
                    refresh_cycle <= 1'b0; // refresh needs one more step
                    acc_step      <= '0;
                end
                default: begin
                    cmd <= sdram_cmd_pkg::nop;
                end
            endcase
        end
    end

    // payload latched at accept, burst words captured in steps 4 and 5
    always_ff @(posedge clk) begin
        if (start) begin
            col_addr <= req_in.req.addr[mem_req_pkg::COL_W-1:0];
            dq_out   <= req_in.req.data;
            wr_mask  <= req_in.req.mask;
        end
        if (read_cycle && acc_step == 3'd4)
            data_read[15:0] <= sdram_dq;  // first word low
        if (read_cycle && acc_step == 3'd5)
            data_read[31:16] <= sdram_dq; // second word high
    end

endmodule

`default_nettype wire

// File: rtl/sdram_sub_top.sv
// sdram subsystem top, request merger, request queue and controller
`timescale 1ns/100ps
`default_nettype none

module sdram_sub_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          refresh_en,
    // rom download
    input  logic                          downloading,
    input  logic                          prog_we,
    input  mem_req_pkg::addr_t            prog_addr,
    input  mem_req_pkg::bank_t            prog_bank,
    input  byte                           prog_data,
    input  mem_req_pkg::mask_t            prog_mask,
    // game side
    input  logic                          read_req,
    input  logic                          rnw,
    input  mem_req_pkg::addr_t            game_addr,
    input  mem_req_pkg::bank_t            game_bank,
    input  mem_req_pkg::word_t            data_write,
    input  mem_req_pkg::mask_t            wr_mask,
    output logic                          sdram_ack,
    output logic                          data_rdy,
    output mem_req_pkg::dword_t           data_read,
    output logic                          init_busy,
    // sdram pins
    inout  wire mem_req_pkg::word_t       sdram_dq,
    output logic [mem_req_pkg::ROW_W-1:0] sdram_a,
    output mem_req_pkg::bank_t            sdram_ba,
    output logic                          sdram_dqml,
    output logic                          sdram_dqmh,
    output logic                          sdram_n_cs,
    output logic                          sdram_n_ras,
    output logic                          sdram_n_cas,
    output logic                          sdram_n_we,
    output logic                          sdram_cke
);

    mem_req_if merge_q ();  // merger to queue
    mem_req_if q_ctrl ();   // queue to controller

    req_merge u_merge (
        .clk, .rst, .downloading, .prog_we, .prog_addr, .prog_bank,
        .prog_data, .prog_mask, .read_req, .rnw, .game_addr, .game_bank,
        .data_write, .wr_mask, .sdram_ack,
        .req_out (merge_q.source)
    );

    req_queue #(.DEPTH(mem_req_pkg::QUEUE_DEPTH)) u_queue (
        .clk, .rst,
        .push_side (merge_q.sink),
        .pop_side  (q_ctrl.source)
    );

    sdram_ctrl u_ctrl (
        .clk, .rst, .refresh_en,
        .req_in (q_ctrl.sink),
        .init_busy, .data_rdy, .data_read,
        .sdram_dq, .sdram_a, .sdram_ba, .sdram_dqml, .sdram_dqmh,
        .sdram_n_cs, .sdram_n_ras, .sdram_n_cas, .sdram_n_we, .sdram_cke
    );

endmodule

`default_nettype wire

// File: src.f
rtl/sdram_cmd_pkg.sv
rtl/mem_req_pkg.sv
rtl/mem_req_if.sv
rtl/req_merge.sv
rtl/req_queue.sv
rtl/sdram_ctrl.sv
rtl/sdram_sub_top.sv
verif/sdram_model.sv
verif/tb_sdram.sv

// File: verif/sdram_model.sv
// behavioral sdram with command decode, masked word store and two-word read burst
`timescale 1ns/100ps
`default_nettype none

module sdram_model (
    input  logic               clk,
    inout  wire mem_req_pkg::word_t dq,
    input  logic [12:0]        a,
    input  mem_req_pkg::bank_t ba,
    input  logic               dqml,
    input  logic               dqmh,
    input  logic               n_cs,
    input  logic               n_ras,
    input  logic               n_cas,
    input  logic               n_we,
    input  logic               cke
);

    sdram_cmd_pkg::cmd_t cmd;
    mem_req_pkg::word_t  mem [int];  // key is {bank, row, col}
    logic [12:0]         open_row [4];
    mem_req_pkg::word_t  rd_word;
    logic                rd_drive;
    logic                rd_second;  // second burst word still to come
    int                  rd_key;

    assign cmd = n_cs ? sdram_cmd_pkg::inhibit
               : sdram_cmd_pkg::cmd_t'({n_cs, n_ras, n_cas, n_we});
    assign dq  = rd_drive ? rd_word : 'z;

    // unwritten cells return a pattern built from the whole address
    function automatic mem_req_pkg::word_t fetch(int key);
        logic [23:0] k;
        k = key[23:0];
        if (mem.exists(key))
            return mem[key];
        return k[15:0] ^ {k[23:16], k[23:16]} ^ 16'ha55a;
    endfunction

    initial begin
        rd_drive  = 1'b0;
        rd_second = 1'b0;
    end

    always @(posedge clk) begin
        int key;
        mem_req_pkg::word_t w;
        if (rd_second) begin
            rd_word   <= fetch(rd_key);
            rd_second <= 1'b0;
        end else begin
            rd_drive <= 1'b0; // burst done
        end
        if (cke) begin
            key = {ba, open_row[ba], a[8:0]};
            case (cmd)
                sdram_cmd_pkg::activate:  open_row[ba] = a;
                sdram_cmd_pkg::write: begin
                    w = fetch(key);
                    if (!dqml)
                        w[7:0] = dq[7:0];
                    if (!dqmh)
                        w[15:8] = dq[15:8];
                    mem[key] = w; // single-location write burst
                end
                sdram_cmd_pkg::read: begin
                    rd_word   <= fetch(key);
                    rd_drive  <= 1'b1;
                    rd_second <= 1'b1;
                    rd_key    <= key ^ 1; // sequential wrap in burst of 2
                end
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verif/tb_sdram.sv
// sdram subsystem testbench with stimulus table, scoreboard, pin monitor and watchdog
`timescale 1ns/100ps
`default_nettype none

module tb_sdram;

    localparam int K_WR = 0, K_RD = 1, K_DL = 2, K_IDLE = 3, K_QUIET = 4, K_HOLD = 5;
    localparam int MAX_ENTRIES = 32;

    logic clk, rst, refresh_en, downloading, prog_we, read_req, rnw;
    mem_req_pkg::addr_t  prog_addr, game_addr;
    mem_req_pkg::bank_t  prog_bank, game_bank;
    byte                 prog_data;
    mem_req_pkg::mask_t  prog_mask, wr_mask;
    mem_req_pkg::word_t  data_write;
    logic                sdram_ack, data_rdy, init_busy;
    mem_req_pkg::dword_t data_read;
    wire mem_req_pkg::word_t sdram_dq;
    logic [12:0]         sdram_a;
    mem_req_pkg::bank_t  sdram_ba;
    logic sdram_dqml, sdram_dqmh, sdram_n_cs, sdram_n_ras, sdram_n_cas, sdram_n_we, sdram_cke;

    int                 tkind [MAX_ENTRIES];
    mem_req_pkg::addr_t taddr [MAX_ENTRIES];
    mem_req_pkg::bank_t tbank [MAX_ENTRIES];
    mem_req_pkg::word_t tdata [MAX_ENTRIES];
    mem_req_pkg::mask_t tmask [MAX_ENTRIES];
    int n_entries = 0;
    int seed = 56604;

    mem_req_pkg::word_t  sb [int];   // expected memory contents
    logic                exp_rd [$]; // completions still owed in request order
    mem_req_pkg::dword_t exp_val [$];
    sdram_cmd_pkg::cmd_t init_log [$];
    logic [12:0]         init_a [$];
    sdram_cmd_pkg::cmd_t pin_cmd;
    int ack_cnt = 0, game_cnt = 0, ref_cnt = 0, cyc = 0, first_cmd_cyc = -1;
    int snap;

    assign pin_cmd = sdram_n_cs ? sdram_cmd_pkg::inhibit
                   : sdram_cmd_pkg::cmd_t'({sdram_n_cs, sdram_n_ras, sdram_n_cas, sdram_n_we});

    sdram_sub_top uut (.*);

    sdram_model u_model (
        .clk, .dq(sdram_dq), .a(sdram_a), .ba(sdram_ba), .dqml(sdram_dqml), .dqmh(sdram_dqmh),
        .n_cs(sdram_n_cs), .n_ras(sdram_n_ras), .n_cas(sdram_n_cas), .n_we(sdram_n_we),
        .cke(sdram_cke)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period
    end

    task automatic stop_on_error();
        $display("Test FAILED");
        $fatal(1);
    endtask

    task automatic check_dword(string name, mem_req_pkg::dword_t exp, mem_req_pkg::dword_t got);
        if (got !== exp) begin
            $display("Fail %s exp %h got %h", name, exp, got);
            stop_on_error();
        end
    endtask

    task automatic check_cmd(string name, sdram_cmd_pkg::cmd_t exp, sdram_cmd_pkg::cmd_t got);
        if (got !== exp) begin
            $display("Fail %s exp %h got %h", name, exp, got);
            stop_on_error();
        end
    endtask

    task automatic check_flag(string name, logic exp, logic got);
        if (got !== exp) begin
            $display("Fail %s exp %h got %h", name, exp, got);
            stop_on_error();
        end
    endtask

    // stops the run when a condition does not hold
    task automatic fail_unless(logic ok, string what);
        if (ok !== 1'b1) begin
            $display("%s", what);
            stop_on_error();
        end
    endtask

    function automatic int sb_key(mem_req_pkg::bank_t b, mem_req_pkg::addr_t a);
        return {b, a};
    endfunction

    // a set mask bit keeps the old byte
    function automatic mem_req_pkg::word_t merge_bytes(mem_req_pkg::word_t old_w,
            mem_req_pkg::word_t new_w, mem_req_pkg::mask_t m);
        return {m[1] ? old_w[15:8] : new_w[15:8], m[0] ? old_w[7:0] : new_w[7:0]};
    endfunction

    function automatic mem_req_pkg::addr_t rand_addr();
        return mem_req_pkg::addr_t'($random(seed)) & ~22'd1; // even column
    endfunction

    task automatic add_entry(int k, mem_req_pkg::addr_t a, mem_req_pkg::bank_t b,
            mem_req_pkg::mask_t m);
        tkind[n_entries] = k;
        taddr[n_entries] = a;
        tbank[n_entries] = b;
        tdata[n_entries] = mem_req_pkg::word_t'($random(seed));
        tmask[n_entries] = m;
        n_entries++;
    endtask

    task automatic build_table();
        mem_req_pkg::addr_t a_ad, b_ad, c_ad, d_ad, e_ad;
        a_ad = rand_addr();
        b_ad = rand_addr();
        c_ad = rand_addr();
        d_ad = rand_addr();
        e_ad = rand_addr();
        add_entry(K_WR, a_ad, 1, 2'b00);
        add_entry(K_WR, a_ad + 1, 1, 2'b00);
        add_entry(K_WR, b_ad, 2, 2'b00);
        add_entry(K_WR, b_ad + 1, 2, 2'b00);
        add_entry(K_WR, c_ad, 0, 2'b00);
        add_entry(K_WR, c_ad + 1, 0, 2'b00);
        add_entry(K_RD, a_ad, 1, 2'b00);
        add_entry(K_RD, b_ad, 2, 2'b00);
        add_entry(K_RD, c_ad, 0, 2'b00);
        add_entry(K_WR, a_ad, 1, 2'b01);     // low byte blocked
        add_entry(K_WR, a_ad + 1, 1, 2'b10); // high byte blocked
        add_entry(K_RD, a_ad, 1, 2'b00);
        add_entry(K_DL, d_ad, 3, 2'b00);
        add_entry(K_DL, d_ad + 1, 3, 2'b00);
        add_entry(K_DL, d_ad, 3, 2'b10);
        add_entry(K_DL, d_ad + 1, 3, 2'b01);
        add_entry(K_HOLD, d_ad, 3, 2'b00);   // read held off by download
        add_entry(K_IDLE, '0, 0, 2'b00);
        add_entry(K_RD, b_ad, 2, 2'b00);
        add_entry(K_RD, c_ad, 0, 2'b00);
        add_entry(K_RD, d_ad, 3, 2'b00);
        add_entry(K_QUIET, '0, 0, 2'b00);
        for (int j = 0; j < 4; j++)
            add_entry(K_WR, e_ad + j, 1, 2'b00);
        add_entry(K_RD, e_ad, 1, 2'b00);
        add_entry(K_RD, e_ad + 2, 1, 2'b00);
        add_entry(K_RD, a_ad, 1, 2'b00);
    endtask

    // scoreboard update and expected completion in queue order
    task automatic record_request(logic wr, int key, mem_req_pkg::word_t d, mem_req_pkg::mask_t m);
        if (wr) begin
            sb[key] = merge_bytes(sb.exists(key) ? sb[key] : 16'h0000, d, m);
            exp_val.push_back('0);
        end else begin
            exp_val.push_back({sb[key + 1], sb[key]}); // second word high
        end
        exp_rd.push_back(!wr);
    endtask

    task automatic drive_game(int i);
        read_req   <= 1'b1;
        rnw        <= (tkind[i] != K_WR);
        game_addr  <= taddr[i];
        game_bank  <= tbank[i];
        data_write <= tdata[i];
        wr_mask    <= tmask[i];
    endtask

    task automatic finish_game(int i);
        do
            @(posedge clk);
        while (sdram_ack !== 1'b1);
        read_req <= 1'b0;
        game_cnt++;
        record_request(tkind[i] == K_WR, sb_key(tbank[i], taddr[i]), tdata[i], tmask[i]);
    endtask

    task automatic wait_drain();
        while (exp_val.size() != 0)
            @(posedge clk);
    endtask

    task automatic apply_entry(int i);
        case (tkind[i])
            K_WR, K_RD: begin
                @(posedge clk);
                downloading <= 1'b0;
                drive_game(i);
                finish_game(i);
            end
            K_DL: begin
                wait_drain(); // pulses spaced by queue drain
                @(posedge clk);
                downloading <= 1'b1;
                prog_we     <= 1'b1;
                prog_addr   <= taddr[i];
                prog_bank   <= tbank[i];
                prog_data   <= tdata[i][7:0];
                prog_mask   <= tmask[i];
                @(posedge clk);
                prog_we <= 1'b0;
                record_request(1'b1, sb_key(tbank[i], taddr[i]),
                               {tdata[i][7:0], tdata[i][7:0]}, tmask[i]);
                wait_drain();
            end
            K_HOLD: begin
                @(posedge clk);
                downloading <= 1'b1;
                drive_game(i);
                repeat (12) begin
                    @(posedge clk);
                    check_flag("sdram_ack", 1'b0, sdram_ack);
                end
                downloading <= 1'b0;
                finish_game(i);
            end
            K_IDLE: begin
                wait_drain();
                @(posedge clk);
                refresh_en <= 1'b1; // stays on for the following reads
                repeat (3) @(posedge clk);
                snap = ref_cnt;
                repeat (20) @(posedge clk);
                fail_unless(ref_cnt > snap, "no auto refresh seen while refresh was enabled");
            end
            default: begin
                wait_drain();
                @(posedge clk);
                refresh_en <= 1'b0;
                repeat (10) @(posedge clk); // let a pending refresh go out
                snap = ref_cnt;
                repeat (20) @(posedge clk);
                fail_unless(ref_cnt == snap, "auto refresh seen while refresh was disabled");
            end
        endcase
    endtask

    // pin and result monitor
    always @(posedge clk) begin
        if (!rst) begin
            cyc++;
            if (init_busy) begin
                check_flag("sdram_ack", 1'b0, sdram_ack);
                check_flag("data_rdy", 1'b0, data_rdy);
                if (pin_cmd != sdram_cmd_pkg::nop && pin_cmd != sdram_cmd_pkg::inhibit) begin
                    if (first_cmd_cyc < 0)
                        first_cmd_cyc = cyc;
                    init_log.push_back(pin_cmd);
                    init_a.push_back(sdram_a);
                end
            end else if (pin_cmd == sdram_cmd_pkg::auto_refresh) begin
                ref_cnt++;
            end
            if (sdram_ack === 1'b1)
                ack_cnt++;
            if (data_rdy === 1'b1) begin
                fail_unless(exp_val.size() != 0, "data_rdy pulsed with no request outstanding");
                if (exp_rd.pop_front())
                    check_dword("data_read", exp_val.pop_front(), data_read);
                else
                    void'(exp_val.pop_front());
            end
        end
    end

    initial begin
        @(posedge clk);
        repeat (sdram_cmd_pkg::INIT_WAIT + 40 + n_entries * 20) @(posedge clk);
        $display("timeout, the run did not finish in the expected time");
        $display("Test FAILED");
        $fatal(1);
    end

    initial begin
        rst = 1'b1;
        refresh_en = 1'b0;
        downloading = 1'b0;
        prog_we = 1'b0;
        prog_addr = '0;
        prog_bank = '0;
        prog_data = 8'h00;
        prog_mask = '0;
        read_req = 1'b0;
        rnw = 1'b1;
        game_addr = '0;
        game_bank = '0;
        data_write = '0;
        wr_mask = '0;
        build_table();
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_flag("init_busy", 1'b1, init_busy);
        while (init_busy)
            @(posedge clk);
        // power-up order on the pins
        fail_unless(init_log.size() == 4, "power-up did not issue exactly four commands");
        fail_unless(first_cmd_cyc >= int'(sdram_cmd_pkg::INIT_WAIT),
                    "power-up command issued before the idle time ended");
        check_cmd("init_cmd0", sdram_cmd_pkg::precharge, init_log[0]);
        check_flag("sdram_a10", 1'b1, init_a[0][10]);
        check_cmd("init_cmd1", sdram_cmd_pkg::auto_refresh, init_log[1]);
        check_cmd("init_cmd2", sdram_cmd_pkg::load_mode, init_log[2]);
        check_dword("sdram_a", 32'(sdram_cmd_pkg::MODE_WORD), 32'(init_a[2]));
        check_cmd("init_cmd3", sdram_cmd_pkg::precharge, init_log[3]);
        check_flag("sdram_a10", 1'b1, init_a[3][10]);
        for (int i = 0; i < n_entries; i++)
            apply_entry(i);
        wait_drain();
        repeat (12) @(posedge clk); // long enough for a stray completion to show
        check_dword("ack_count", 32'(game_cnt), 32'(ack_cnt));
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire
